/* hdl/exu_defines.svh */
// ==========================================================
// exu widths and address map
// register count, word widths and the AXI4-Lite byte
// addresses of the operation, flag and status words
// ==========================================================

`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// datapath
`define EXU_DATA_W 32
`define EXU_NREGS 16
`define EXU_REG_AW 4

// host bus
`define EXU_ADDR_W 8

// status counters, wrap at 2**w
`define EXU_CNT_W 8

// r0..r15 sit below the op word at 0x00..0x3c
`define EXU_OP_ADDR 8'h40
`define EXU_FLAGS_ADDR 8'h44
`define EXU_STATUS_ADDR 8'h48

`endif

/* hdl/exu_pkg.sv */
// ==========================================================
// exu types
// data and index vectors, opcode and condition encodings,
// and the structs passed between decode, ALU and regfile
// ==========================================================

`include "exu_defines.svh"

package exu_pkg;

  typedef logic [`EXU_DATA_W-1:0] data_t;
  typedef logic [`EXU_REG_AW-1:0] reg_idx_t;
  typedef logic [`EXU_ADDR_W-1:0] axil_addr_t;
  typedef logic [`EXU_CNT_W-1:0] cnt_t;

  typedef enum logic [3:0] {
    OP_ADD = 4'd0, OP_SUB = 4'd1, OP_AND = 4'd2, OP_OR  = 4'd3, OP_XOR = 4'd4,
    OP_SHL = 4'd5, OP_SHR = 4'd6, OP_SAR = 4'd7, OP_MOV = 4'd8, OP_CMP = 4'd9
  } alu_op_e;  // 10..15 rejected by decode

  typedef enum logic [3:0] {
    COND_AL = 4'd0,  COND_NV = 4'd1,  COND_EQ = 4'd2,  COND_NE = 4'd3,
    COND_CS = 4'd4,  COND_CC = 4'd5,  COND_MI = 4'd6,  COND_PL = 4'd7,
    COND_VS = 4'd8,  COND_VC = 4'd9,  COND_HI = 4'd10, COND_LS = 4'd11,
    COND_GE = 4'd12, COND_LT = 4'd13, COND_GT = 4'd14, COND_LE = 4'd15
  } cond_e;

  typedef struct packed {
    logic v;
    logic c;
    logic n;
    logic z;
  } flags_t;

  // same layout as the low bits of the operation word
  typedef struct packed {
    cond_e    cond;
    reg_idx_t src_b;
    reg_idx_t src_a;
    reg_idx_t dst;
    alu_op_e  opcode;
  } exu_op_t;

  typedef struct packed {
    logic     en;        // register write
    reg_idx_t dst;
    data_t    data;
    logic     flags_en;  // op executed
    flags_t   flags;
    logic     skipped;   // condition false
  } wb_t;

  typedef struct packed {
    logic     reg_en;
    logic     flags_en;
    reg_idx_t idx;
    data_t    data;
  } host_wr_t;

endpackage

/* hdl/exu_cmd_decode.sv */
// ==========================================================
// exu command decode
// AXI4-Lite write slave; turns accepted writes into host
// register and flag writes or issued ALU operations, and
// holds the write response until the master takes it
// ==========================================================

`timescale 1ns/1ns

`include "exu_defines.svh"

module exu_cmd_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  exu_pkg::axil_addr_t  awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  exu_pkg::data_t       wdata,
  input  logic                 wvalid,
  output logic                 wready,
  output logic [1:0]           bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  logic                 busy,
  output exu_pkg::host_wr_t    host_wr,
  output logic                 issue_valid,
  output exu_pkg::exu_op_t     issue_op
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic is_reg;
  logic is_op;
  logic is_flags;
  logic legal_op;
  logic host_sel;
  logic wr_err;
  logic wr_go;

  // address map
  assign is_reg   = (awaddr < `EXU_OP_ADDR) && (awaddr[1:0] == 2'b00);
  assign is_op    = (awaddr == `EXU_OP_ADDR);
  assign is_flags = (awaddr == `EXU_FLAGS_ADDR);

  assign legal_op = (wdata[3:0] <= 4'(exu_pkg::OP_CMP));

  // status, unmapped and bad opcodes all end up here
  assign wr_err = !(is_reg || is_flags || (is_op && legal_op));

  // host writes must not collide with a pipeline writeback
  assign host_sel = is_reg || is_flags;

  assign wr_go   = awvalid && wvalid && !bvalid && !(host_sel && busy);
  assign awready = wr_go;
  assign wready  = wr_go;

  assign host_wr.reg_en   = wr_go && is_reg;
  assign host_wr.flags_en = wr_go && is_flags;
  assign host_wr.idx      = awaddr[`EXU_REG_AW+1:2];
  assign host_wr.data     = wdata;

  assign issue_valid = wr_go && is_op && legal_op;
  assign issue_op    = exu_pkg::exu_op_t'(wdata[$bits(exu_pkg::exu_op_t)-1:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
      bresp  <= RESP_OKAY;
    end else if (wr_go) begin
      bvalid <= 1'b1;
      bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // response held steady under back-pressure
  a_bresp_hold: assert property (
    @(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp)
  );

endmodule

/* hdl/exu_regfile.sv */
// ==========================================================
// exu register file
// sixteen data words plus the flag word, written by the
// host or by pipeline writeback, three async read ports
// ==========================================================

`timescale 1ns/1ns

`include "exu_defines.svh"

module exu_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  exu_pkg::host_wr_t    host_wr,
  input  exu_pkg::wb_t         wb,
  input  exu_pkg::reg_idx_t    rd_a_idx,
  output exu_pkg::data_t       rd_a,
  input  exu_pkg::reg_idx_t    rd_b_idx,
  output exu_pkg::data_t       rd_b,
  input  exu_pkg::reg_idx_t    rd_c_idx,
  output exu_pkg::data_t       rd_c,
  output exu_pkg::flags_t      flags
);

  exu_pkg::data_t regs [`EXU_NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `EXU_NREGS; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
    end else begin
      if (host_wr.reg_en) regs[host_wr.idx] <= host_wr.data;
      if (wb.en) regs[wb.dst] <= wb.data;

      // host flag word uses the low data bits
      if (host_wr.flags_en) begin
        flags <= exu_pkg::flags_t'(host_wr.data[$bits(exu_pkg::flags_t)-1:0]);
      end
      if (wb.flags_en) flags <= wb.flags;
    end
  end

  // operand ports for the ALU, third port for the host read side
  assign rd_a = regs[rd_a_idx];
  assign rd_b = regs[rd_b_idx];
  assign rd_c = regs[rd_c_idx];

  // decode holds host writes off while the pipeline is busy
  a_no_write_clash: assert property (
    @(posedge clk) disable iff (rst)
    !((host_wr.reg_en || host_wr.flags_en) && (wb.en || wb.flags_en))
  );

endmodule

/* hdl/exu_alu.sv */
// ==========================================================
// exu ALU pipeline
// stage 1 latches operands and flags with forwarding from
// stage 2; stage 2 tests the condition, computes result
// and flags and presents the writeback
// ==========================================================

`timescale 1ns/1ns

`include "exu_defines.svh"

module exu_alu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_valid,
  input  exu_pkg::exu_op_t     issue_op,
  output exu_pkg::reg_idx_t    rd_a_idx,
  input  exu_pkg::data_t       rd_a,
  output exu_pkg::reg_idx_t    rd_b_idx,
  input  exu_pkg::data_t       rd_b,
  input  exu_pkg::flags_t      flags,
  output exu_pkg::wb_t         wb,
  output logic                 busy
);

  logic                s1_valid;
  exu_pkg::exu_op_t    s1_op;
  exu_pkg::data_t      s1_a;
  exu_pkg::data_t      s1_b;
  exu_pkg::flags_t     s1_flags;
  logic                s2_valid;
  exu_pkg::data_t      fwd_a;
  exu_pkg::data_t      fwd_b;
  exu_pkg::flags_t     fwd_flags;
  logic                cond_true;
  logic                arith;
  logic                sub_op;
  logic                wr_dst;
  exu_pkg::data_t      b_eff;
  logic [`EXU_DATA_W:0] sum;
  exu_pkg::data_t      res;
  exu_pkg::flags_t     res_flags;

  function automatic logic cond_pass(input exu_pkg::cond_e cc, input exu_pkg::flags_t f);
    case (cc)
      exu_pkg::COND_AL: cond_pass = 1'b1;
      exu_pkg::COND_NV: cond_pass = 1'b0;
      exu_pkg::COND_EQ: cond_pass = f.z;
      exu_pkg::COND_NE: cond_pass = !f.z;
      exu_pkg::COND_CS: cond_pass = f.c;
      exu_pkg::COND_CC: cond_pass = !f.c;
      exu_pkg::COND_MI: cond_pass = f.n;
      exu_pkg::COND_PL: cond_pass = !f.n;
      exu_pkg::COND_VS: cond_pass = f.v;
      exu_pkg::COND_VC: cond_pass = !f.v;
      exu_pkg::COND_HI: cond_pass = f.c && !f.z;
      exu_pkg::COND_LS: cond_pass = !f.c || f.z;
      exu_pkg::COND_GE: cond_pass = (f.n == f.v);
      exu_pkg::COND_LT: cond_pass = (f.n != f.v);
      exu_pkg::COND_GT: cond_pass = !f.z && (f.n == f.v);
      default:          cond_pass = f.z || (f.n != f.v);  // LE
    endcase
  endfunction

  assign rd_a_idx = issue_op.src_a;
  assign rd_b_idx = issue_op.src_b;

  // regfile not yet written for the op in stage 2
  assign fwd_a     = (wb.en && wb.dst == issue_op.src_a) ? wb.data : rd_a;
  assign fwd_b     = (wb.en && wb.dst == issue_op.src_b) ? wb.data : rd_b;
  assign fwd_flags = wb.flags_en ? wb.flags : flags;

  always_ff @(posedge clk) begin
    if (rst) s1_valid <= 1'b0;
    else s1_valid <= issue_valid;
    s1_op    <= issue_op;
    s1_a     <= fwd_a;
    s1_b     <= fwd_b;
    s1_flags <= fwd_flags;
  end

  assign cond_true = cond_pass(s1_op.cond, s1_flags);

  always_comb begin
    arith  = (s1_op.opcode inside {exu_pkg::OP_ADD, exu_pkg::OP_SUB, exu_pkg::OP_CMP});
    sub_op = (s1_op.opcode != exu_pkg::OP_ADD);
    b_eff  = sub_op ? ~s1_b : s1_b;
    sum    = {1'b0, s1_a} + {1'b0, b_eff} + sub_op;  // carry out is no-borrow on sub
    wr_dst = (s1_op.opcode != exu_pkg::OP_CMP);
    case (s1_op.opcode)
      exu_pkg::OP_AND: res = s1_a & s1_b;
      exu_pkg::OP_OR:  res = s1_a | s1_b;
      exu_pkg::OP_XOR: res = s1_a ^ s1_b;
      exu_pkg::OP_SHL: res = s1_a << s1_b[4:0];
      exu_pkg::OP_SHR: res = s1_a >> s1_b[4:0];
      exu_pkg::OP_SAR: res = exu_pkg::data_t'($signed(s1_a) >>> s1_b[4:0]);
      exu_pkg::OP_MOV: res = s1_b;
      default:         res = sum[`EXU_DATA_W-1:0];
    endcase
    res_flags   = s1_flags;  // logic ops keep c and v
    res_flags.z = (res == '0);
    res_flags.n = res[`EXU_DATA_W-1];
    if (arith) begin
      res_flags.c = sum[`EXU_DATA_W];
      res_flags.v = (s1_a[`EXU_DATA_W-1] == b_eff[`EXU_DATA_W-1]) &&
                    (res[`EXU_DATA_W-1] != s1_a[`EXU_DATA_W-1]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid    <= 1'b0;
      wb.en       <= 1'b0;
      wb.flags_en <= 1'b0;
      wb.skipped  <= 1'b0;
    end else begin
      s2_valid    <= s1_valid;
      wb.en       <= s1_valid && cond_true && wr_dst;
      wb.flags_en <= s1_valid && cond_true;
      wb.skipped  <= s1_valid && !cond_true;
    end
    wb.dst   <= s1_op.dst;
    wb.data  <= res;
    wb.flags <= res_flags;
  end

  assign busy = s1_valid || s2_valid;

  a_wb_dst_known: assert property (
    @(posedge clk) disable iff (rst)
    wb.en |-> !$isunknown(wb.dst)
  );

  // forwarding only covers stage 2, so decode must space issues
  a_issue_spacing: assert property (
    @(posedge clk) disable iff (rst)
    issue_valid |=> !issue_valid
  );

endmodule

/* hdl/exu_read_port.sv */
// ==========================================================
// exu read port
// AXI4-Lite read slave for registers, flags and status;
// counts executed and skipped ops from the writeback
// ==========================================================

`timescale 1ns/1ns

`include "exu_defines.svh"

module exu_read_port (
  input  logic                 clk,
  input  logic                 rst,
  input  exu_pkg::axil_addr_t  araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output exu_pkg::data_t       rdata,
  output logic [1:0]           rresp,
  output logic                 rvalid,
  input  logic                 rready,
  output exu_pkg::reg_idx_t    rd_c_idx,
  input  exu_pkg::data_t       rd_c,
  input  exu_pkg::flags_t      flags,
  input  logic                 busy,
  input  exu_pkg::wb_t         wb
);

  logic           ar_open;  // low only while in reset
  logic           rd_go;
  logic           rd_err;
  exu_pkg::data_t rd_sel;
  exu_pkg::cnt_t  exec_cnt;
  exu_pkg::cnt_t  skip_cnt;

  assign arready  = ar_open && !rvalid;
  assign rd_go    = arvalid && arready;
  assign rd_c_idx = araddr[`EXU_REG_AW+1:2];

  always_comb begin
    rd_sel = '0;
    rd_err = 1'b0;
    if (araddr < `EXU_OP_ADDR && araddr[1:0] == 2'b00) begin
      rd_sel = rd_c;
    end else if (araddr == `EXU_FLAGS_ADDR) begin
      rd_sel = {{(`EXU_DATA_W-$bits(exu_pkg::flags_t)){1'b0}}, flags};
    end else if (araddr == `EXU_STATUS_ADDR) begin
      rd_sel = {8'h00, skip_cnt, exec_cnt, 7'h00, busy};
    end else begin
      rd_err = 1'b1;  // op word reads back as unmapped
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ar_open  <= 1'b0;
      rvalid   <= 1'b0;
      rresp    <= 2'b00;
      exec_cnt <= '0;
      skip_cnt <= '0;
    end else begin
      ar_open <= 1'b1;
      if (rd_go) begin
        rvalid <= 1'b1;
        rresp  <= rd_err ? 2'b10 : 2'b00;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (wb.flags_en) exec_cnt <= exec_cnt + 1'b1;  // every executed op sets flags
      if (wb.skipped) skip_cnt <= skip_cnt + 1'b1;
    end
    if (rd_go) rdata <= rd_sel;
  end

endmodule

/* hdl/exu_top.sv */
// ==========================================================
// exu top
// predicated integer execution unit behind an AXI4-Lite
// slave; write decode, ALU pipeline, regfile, read port
// ==========================================================

`timescale 1ns/1ns

module exu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  exu_pkg::axil_addr_t  awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  exu_pkg::data_t       wdata,
  input  logic                 wvalid,
  output logic                 wready,
  output logic [1:0]           bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  exu_pkg::axil_addr_t  araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output exu_pkg::data_t       rdata,
  output logic [1:0]           rresp,
  output logic                 rvalid,
  input  logic                 rready
);

  logic               busy;
  logic               issue_valid;
  exu_pkg::exu_op_t   issue_op;
  exu_pkg::host_wr_t  host_wr;
  exu_pkg::wb_t       wb;
  exu_pkg::reg_idx_t  rd_a_idx;
  exu_pkg::reg_idx_t  rd_b_idx;
  exu_pkg::reg_idx_t  rd_c_idx;
  exu_pkg::data_t     rd_a;
  exu_pkg::data_t     rd_b;
  exu_pkg::data_t     rd_c;
  exu_pkg::flags_t    flags;

  exu_cmd_decode u_cmd_decode (
    .clk, .rst,
    .awaddr, .awvalid, .awready,
    .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .busy, .host_wr, .issue_valid, .issue_op
  );

  exu_regfile u_regfile (
    .clk, .rst, .host_wr, .wb,
    .rd_a_idx, .rd_a, .rd_b_idx, .rd_b, .rd_c_idx, .rd_c,
    .flags
  );

  exu_alu u_alu (
    .clk, .rst, .issue_valid, .issue_op,
    .rd_a_idx, .rd_a, .rd_b_idx, .rd_b,
    .flags, .wb, .busy
  );

  exu_read_port u_read_port (
    .clk, .rst,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .rd_c_idx, .rd_c, .flags, .busy, .wb
  );

endmodule

/* verif/exu_tb.sv */
// ==========================================================
// exu testbench
// directed tests over AXI4-Lite, checked against a model
// of the registers, flags and status counters
// ==========================================================

`timescale 1ns/1ns

`include "exu_defines.svh"

module exu_tb;

  localparam int TIMEOUT_CYCLES = 20000;  // ~600 transactions, under 30 cycles each

  logic                clk;
  logic                rst;
  exu_pkg::axil_addr_t awaddr;
  logic                awvalid;
  logic                awready;
  exu_pkg::data_t      wdata;
  logic                wvalid;
  logic                wready;
  logic [1:0]          bresp;
  logic                bvalid;
  logic                bready;
  exu_pkg::axil_addr_t araddr;
  logic                arvalid;
  logic                arready;
  exu_pkg::data_t      rdata;
  logic [1:0]          rresp;
  logic                rvalid;
  logic                rready;

  exu_pkg::data_t  m_regs [`EXU_NREGS];
  exu_pkg::flags_t m_flags = '0;
  int              m_exec = 0;
  int              m_skip = 0;
  int              cycles = 0;
  int              errors = 0;
  int              checks = 0;
  int              test_errors = 0;
  int              tests = 0;

  exu_top dut (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s finished with %0d mismatches", tests, name, test_errors);
    test_errors = 0;
  endtask

  // waits for the aw/w handshake, then drops both valids
  task automatic await_aw();
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  // b handshake completes on the coming edge, next write may start there
  task automatic take_resp(output logic [1:0] resp);
    @(negedge clk);
    while (!(bvalid && bready)) @(negedge clk);
    resp = bresp;
  endtask

  task automatic axil_write(input exu_pkg::axil_addr_t addr, input exu_pkg::data_t data,
                            output logic [1:0] resp);
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    await_aw();
    take_resp(resp);
  endtask

  task automatic axil_read(input exu_pkg::axil_addr_t addr, output exu_pkg::data_t data,
                           output logic [1:0] resp);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
  endtask

  task automatic write_reg(input int idx, input exu_pkg::data_t val);
    logic [1:0] resp;
    axil_write(8'(idx * 4), val, resp);
    compare(resp, 2'b00, "register write response");
    m_regs[idx] = val;
  endtask

  task automatic write_flags(input exu_pkg::flags_t f);
    logic [1:0] resp;
    axil_write(`EXU_FLAGS_ADDR, {28'h0, f}, resp);
    compare(resp, 2'b00, "flag write response");
    m_flags = f;
  endtask

  task automatic expect_reg(input int idx);
    exu_pkg::data_t d;
    logic [1:0]     resp;
    axil_read(8'(idx * 4), d, resp);
    compare(resp, 2'b00, $sformatf("r%0d read response", idx));
    compare(d, m_regs[idx], $sformatf("r%0d value", idx));
  endtask

  task automatic expect_flags();
    exu_pkg::data_t d;
    logic [1:0]     resp;
    axil_read(`EXU_FLAGS_ADDR, d, resp);
    compare(d, {28'h0, m_flags}, "flag word");
  endtask

  task automatic status_counts();
    exu_pkg::data_t st;
    logic [1:0]     resp;
    axil_read(`EXU_STATUS_ADDR, st, resp);
    compare(st[15:8], m_exec[7:0], "executed count");
    compare(st[23:16], m_skip[7:0], "skipped count");
  endtask

  task automatic wait_idle();
    exu_pkg::data_t st;
    logic [1:0]     resp;
    st = 32'h1;
    while (st[0]) axil_read(`EXU_STATUS_ADDR, st, resp);
  endtask

  function automatic bit cond_holds(input int cc, input exu_pkg::flags_t f);
    case (cc)
      0: return 1'b1;
      1: return 1'b0;
      2: return f.z;
      3: return !f.z;
      4: return f.c;
      5: return !f.c;
      6: return f.n;
      7: return !f.n;
      8: return f.v;
      9: return !f.v;
      10: return f.c && !f.z;
      11: return !(f.c && !f.z);
      12: return f.n == f.v;
      13: return f.n != f.v;
      14: return !f.z && (f.n == f.v);
      default: return !(!f.z && (f.n == f.v));
    endcase
  endfunction

  function automatic void model_op(input exu_pkg::exu_op_t op);
    exu_pkg::data_t a;
    exu_pkg::data_t b;
    exu_pkg::data_t r;
    logic [32:0]    wide;
    a = m_regs[op.src_a];
    b = m_regs[op.src_b];
    if (!cond_holds(int'(op.cond), m_flags)) begin
      m_skip++;
      return;
    end
    m_exec++;
    case (op.opcode)
      exu_pkg::OP_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        r = wide[31:0];
        m_flags.c = wide[32];
        m_flags.v = (a[31] == b[31]) && (r[31] != a[31]);
      end
      exu_pkg::OP_SUB, exu_pkg::OP_CMP: begin
        r = a - b;
        m_flags.c = (a >= b);  // no borrow
        m_flags.v = (a[31] != b[31]) && (r[31] != a[31]);
      end
      exu_pkg::OP_AND: r = a & b;
      exu_pkg::OP_OR:  r = a | b;
      exu_pkg::OP_XOR: r = a ^ b;
      exu_pkg::OP_SHL: r = a << b[4:0];
      exu_pkg::OP_SHR: r = a >> b[4:0];
      exu_pkg::OP_SAR: begin
        r = a >> b[4:0];
        if (a[31]) r = r | ~(32'hffff_ffff >> b[4:0]);  // fill with sign
      end
      default: r = b;
    endcase
    m_flags.z = (r == 32'h0);
    m_flags.n = r[31];
    if (op.opcode != exu_pkg::OP_CMP) m_regs[op.dst] = r;
  endfunction

  function automatic exu_pkg::exu_op_t make_op(input int opc, input int dst, input int a,
                                               input int b, input int cc);
    exu_pkg::exu_op_t op;
    op.opcode = exu_pkg::alu_op_e'(opc);
    op.dst    = exu_pkg::reg_idx_t'(dst);
    op.src_a  = exu_pkg::reg_idx_t'(a);
    op.src_b  = exu_pkg::reg_idx_t'(b);
    op.cond   = exu_pkg::cond_e'(cc);
    return op;
  endfunction

  task automatic run_op(input exu_pkg::exu_op_t op, input bit wait_done);
    logic [1:0] resp;
    axil_write(`EXU_OP_ADDR, {12'h000, op}, resp);
    compare(resp, 2'b00, "op word response");
    model_op(op);
    if (wait_done) wait_idle();
  endtask

  task automatic reg_readback();
    for (int i = 0; i < `EXU_NREGS; i++) write_reg(i, $urandom);
    for (int i = 0; i < `EXU_NREGS; i++) expect_reg(i);
    end_test("register readback");
  endtask

  task automatic opcode_sweep();
    for (int opc = 0; opc <= 9; opc++) begin
      write_reg(1, $urandom);
      write_reg(2, $urandom);
      run_op(make_op(opc, 3, 1, 2, 0), 1'b1);
      expect_reg(3);
      expect_flags();
    end
    // shift amounts 0 and 31, upper bits of src_b ignored
    write_reg(1, $urandom | 32'h8000_0001);
    write_reg(2, $urandom & ~32'h1f);
    run_op(make_op(5, 4, 1, 2, 0), 1'b1);
    expect_reg(4);
    write_reg(2, $urandom | 32'h1f);
    for (int opc = 5; opc <= 7; opc++) begin
      run_op(make_op(opc, opc, 1, 2, 0), 1'b1);
      expect_reg(opc);
      expect_flags();
    end
    end_test("opcodes");
  endtask

  task automatic cond_sweep();
    write_reg(6, $urandom);
    write_reg(7, $urandom);
    for (int cc = 0; cc < 16; cc++) begin
      for (int k = 0; k < 2; k++) begin
        write_flags(exu_pkg::flags_t'($urandom));
        run_op(make_op(0, 5, 5, 7, cc), 1'b1);  // accumulates, so every execute shows
        expect_reg(5);
        expect_flags();
        status_counts();
      end
    end
    end_test("conditions");
  endtask

  task automatic forward_chain();
    exu_pkg::data_t st;
    logic [1:0]     resp;
    write_reg(9, $urandom);
    write_reg(10, $urandom);
    // issues two cycles apart, operands come from stage 2
    run_op(make_op(0, 8, 9, 10, 0), 1'b0);
    run_op(make_op(0, 8, 8, 9, 0), 1'b0);
    run_op(make_op(0, 8, 8, 8, 3), 1'b0);  // NE, reads the forwarded flags
    axil_read(`EXU_STATUS_ADDR, st, resp);
    compare(st[0], 1'b1, "busy right after the chain");
    wait_idle();
    expect_reg(8);
    expect_flags();
    end_test("dependent chain");
  endtask

  task automatic bad_access();
    logic [1:0]     resp;
    exu_pkg::data_t d;
    axil_write(8'h4c, $urandom, resp);
    compare(resp, 2'b10, "unmapped write response");
    axil_write(`EXU_STATUS_ADDR, 32'hffff_ffff, resp);
    compare(resp, 2'b10, "status write response");
    axil_write(`EXU_OP_ADDR, 32'h0002_130c, resp);  // opcode 12
    compare(resp, 2'b10, "illegal opcode response");
    wait_idle();
    for (int i = 0; i < `EXU_NREGS; i++) expect_reg(i);
    expect_flags();
    status_counts();
    axil_read(8'h80, d, resp);
    compare(resp, 2'b10, "unmapped read response");
    compare(d, 32'h0, "unmapped read data");
    end_test("error responses");
  endtask

  task automatic write_backpressure();
    int             hold;
    logic [1:0]     resp;
    exu_pkg::data_t first;
    exu_pkg::data_t second;
    hold   = 2 + ($urandom % 8);
    first  = $urandom;
    second = $urandom;
    @(posedge clk);
    bready  <= 1'b0;
    awaddr  <= 8'h2c;
    wdata   <= first;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    await_aw();
    m_regs[11] = first;
    @(posedge clk);
    awaddr  <= 8'h30;
    wdata   <= second;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    repeat (hold) begin
      @(negedge clk);
      compare(awready, 1'b0, "write accepted while response held");
      compare(bvalid, 1'b1, "held write response");
    end
    compare(bresp, 2'b00, "held write response code");
    @(posedge clk);
    bready <= 1'b1;
    await_aw();
    take_resp(resp);
    compare(resp, 2'b00, "second write response");
    m_regs[12] = second;
    for (int i = 0; i < `EXU_NREGS; i++) expect_reg(i);
    end_test("write back-pressure");
  endtask

  initial begin
    void'($urandom(32'h51b3));
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    for (int i = 0; i < `EXU_NREGS; i++) m_regs[i] = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    reg_readback();
    opcode_sweep();
    cond_sweep();
    forward_chain();
    bad_access();
    write_backpressure();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_cmd_decode.sv
hdl/exu_regfile.sv
hdl/exu_alu.sv
hdl/exu_read_port.sv
hdl/exu_top.sv
verif/exu_tb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/exu_pkg.sv
      - hdl/exu_cmd_decode.sv
      - hdl/exu_regfile.sv
      - hdl/exu_alu.sv
      - hdl/exu_read_port.sv
      - hdl/exu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/exu_tb.sv
